/* sim.f */
+incdir+.
mipsPkg.sv
cpuControl.sv
regFile.sv
alu.sv
busPort.sv
mipsCpuBus.sv
tbMemory.sv
tbMipsCpu.sv

/* Bender.yml */
package:
  name: mips_cpu_bus

sources:
  - include_dirs:
      - .
    files:
      - mipsPkg.sv
      - cpuControl.sv
      - regFile.sv
      - alu.sv
      - busPort.sv
      - mipsCpuBus.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbMemory.sv
      - tbMipsCpu.sv

/* tbMipsCpu.sv */
// Testbench of the MIPS core, runs a generated program from tbMemory and checks the bus and registerV0
`include "mipsCpu_cfg.svh"

module tbMipsCpu;

    localparam logic [31:0] ResetVector = `MIPS_RESET_VECTOR;
    localparam logic [31:0] DataBase = 32'h0000_0100;
    localparam int ProgLen = 29;

    logic clk;
    logic reset;
    logic active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic [31:0] writeData;
    logic read;
    logic write;
    logic waitRequest;
    logic [3:0] byteEnable;
    logic [31:0] readData;

    logic [31:0] progWords [0:ProgLen-1];
    logic [31:0] fetchAddr [0:63];
    logic [31:0] randState;
    int numFetches = 0;
    int fetchCount;
    int writeCount;
    int errorCount = 0;
    logic readPrev;
    logic fetchStart;
    logic [31:0] expFetch;
    logic [31:0] chainCheckPc;
    logic [31:0] loadCheckPc;
    logic [31:0] expChain;
    logic [31:0] expStoreAddr;
    logic [31:0] storedWord;
    logic [31:0] expFinal;

    mipsCpuBus dut (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .writeData(writeData), .read(read), .write(write),
        .waitRequest(waitRequest), .byteEnable(byteEnable), .readData(readData)
    );

    tbMemory memory (
        .clk(clk), .reset(reset), .address(address), .writeData(writeData),
        .read(read), .write(write), .waitRequest(waitRequest), .readData(readData)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] encodeR(input int rs, input int rt, input int rd,
                                            input int shamt, input logic [5:0] funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs, input int rt,
                                            input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [15:0] drawImmediate();
        randState = memory.nextRandom(randState);
        return randState[31:16];
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
        errorCount++;
    endtask

    task automatic reportProblem(input string what);
        $display("%0t %s", $time, what);
        errorCount++;
    endtask

    // A fetch starts when read rises on a ROM address
    assign fetchStart = read && !readPrev && (address[31:10] == ResetVector[31:10]);
    assign expFetch = (fetchCount < numFetches) ? fetchAddr[fetchCount] : 32'hFFFF_FFFF;

    always @(posedge clk) begin
        if (reset) begin
            readPrev <= 1'b0;
            fetchCount <= 0;
            writeCount <= 0;
        end else begin
            readPrev <= read;
            if (fetchStart) begin
                fetchCount <= fetchCount + 1;
            end
            if (write && !waitRequest) begin
                writeCount <= writeCount + 1;
            end
        end
    end

    resetOutputs: assert property (@(posedge clk) $fell(reset) |-> (!read && !write && active))
        else reportMismatch("read,write,active",
                            {$sampled(read), $sampled(write), $sampled(active)}, 32'b001);
    firstFetch: assert property (@(posedge clk) $fell(reset) |=> read)
        else reportProblem("no fetch in the first cycle after reset");
    exclusiveStrobes: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else reportProblem("read and write were high together");
    holdDuringWait: assert property (@(posedge clk) disable iff (reset)
        ((read || write) && waitRequest) |=> ($stable(address) && $stable(writeData)
                                              && $stable(read) && $stable(write)))
        else reportProblem("bus signals changed while waitRequest was high");
    fullBytes: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> (byteEnable == 4'hF))
        else reportMismatch("byteEnable", $sampled(byteEnable), 32'hF);
    fetchOrder: assert property (@(posedge clk) disable iff (reset)
        fetchStart |-> (address == expFetch))
        else reportMismatch("fetch address", $sampled(address), $sampled(expFetch));
    chainResult: assert property (@(posedge clk) disable iff (reset)
        (read && address == chainCheckPc) |-> (registerV0 == expChain))
        else reportMismatch("registerV0", $sampled(registerV0), expChain);
    storeAddress: assert property (@(posedge clk) disable iff (reset)
        (write && !waitRequest) |-> (address == expStoreAddr))
        else reportMismatch("address", $sampled(address), expStoreAddr);
    storeData: assert property (@(posedge clk) disable iff (reset)
        (write && !waitRequest) |-> (writeData == storedWord))
        else reportMismatch("writeData", $sampled(writeData), storedWord);
    loadResult: assert property (@(posedge clk) disable iff (reset)
        (read && address == loadCheckPc) |-> (registerV0 == storedWord))
        else reportMismatch("registerV0", $sampled(registerV0), storedWord);
    staysHalted: assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else reportProblem("active rose again after the core halted");
    idleAfterHalt: assert property (@(posedge clk) disable iff (reset)
        !active |-> (!read && !write))
        else reportProblem("bus access after the core halted");
    finalResult: assert property (@(posedge clk) disable iff (reset)
        !active |-> (registerV0 == expFinal))
        else reportMismatch("registerV0", $sampled(registerV0), expFinal);

    initial begin : main
        logic [31:0] regs [0:31];
        logic [15:0] immA;
        logic [15:0] immB;
        logic [15:0] immC;
        logic [15:0] immD;
        logic [15:0] immE;
        logic [15:0] shiftA;
        logic [15:0] shiftB;
        logic [31:0] jalTarget;

        reset = 1'b1;
        randState = 32'h8064d201;
        immA = drawImmediate();
        immB = drawImmediate();
        immC = drawImmediate();
        immD = drawImmediate();
        // Top bit set so SRA has to extend the sign
        immE = drawImmediate() | 16'h8000;
        shiftA = drawImmediate();
        shiftB = drawImmediate();
        jalTarget = ResetVector + 32'd104;

        // ALU chain ending in v0
        progWords[0] = encodeI(6'h09, 0, 8, immA);
        progWords[1] = encodeI(6'h0D, 8, 9, immB);
        progWords[2] = encodeI(6'h0E, 9, 10, immC);
        progWords[3] = encodeI(6'h0C, 10, 11, immD);
        progWords[4] = encodeI(6'h0F, 0, 12, immE);
        progWords[5] = encodeR(12, 8, 13, 0, 6'h2A);
        progWords[6] = encodeR(12, 8, 14, 0, 6'h2B);
        progWords[7] = encodeR(0, 9, 15, shiftA[4:0], 6'h00);
        progWords[8] = encodeR(0, 12, 16, shiftB[4:0], 6'h03);
        progWords[9] = encodeR(15, 16, 17, 0, 6'h23);
        progWords[10] = encodeR(13, 14, 18, 0, 6'h21);
        progWords[11] = encodeR(17, 11, 2, 0, 6'h26);
        progWords[12] = encodeR(2, 18, 2, 0, 6'h21);
        // Store $17, clear v0, load it back
        progWords[13] = encodeI(6'h09, 0, 4, DataBase[15:0]);
        progWords[14] = encodeI(6'h2B, 4, 17, 16'h0008);
        progWords[15] = encodeI(6'h09, 0, 2, 16'h0000);
        progWords[16] = encodeI(6'h23, 4, 2, 16'h0008);
        // Each wrong path of the branches and JAL adds a distinct bit to v0
        progWords[17] = encodeI(6'h09, 0, 5, 16'h0001);
        progWords[18] = encodeI(6'h09, 0, 2, 16'h0000);
        progWords[19] = encodeI(6'h04, 5, 5, 16'h0001);
        progWords[20] = encodeI(6'h09, 2, 2, 16'h0100);
        progWords[21] = encodeI(6'h05, 5, 5, 16'h0001);
        progWords[22] = encodeI(6'h09, 2, 2, 16'h0010);
        progWords[23] = {6'h03, jalTarget[27:2]};
        progWords[24] = encodeI(6'h09, 2, 2, 16'h0200);
        progWords[25] = encodeI(6'h09, 2, 2, 16'h0400);
        progWords[26] = encodeI(6'h09, 2, 2, 16'h0001);
        progWords[27] = encodeR(2, 31, 2, 0, 6'h21);
        progWords[28] = encodeR(0, 0, 0, 0, 6'h08);

        for (int i = 0; i < 256; i++) begin
            if (i < ProgLen) begin
                memory.rom[i] = progWords[i];
            end else begin
                memory.rom[i] = memory.fillWord(ResetVector + 4 * i);
            end
        end

        // Expected register values
        regs[8] = {{16{immA[15]}}, immA};
        regs[9] = regs[8] | {16'h0000, immB};
        regs[10] = regs[9] ^ {16'h0000, immC};
        regs[11] = regs[10] & {16'h0000, immD};
        regs[12] = {immE, 16'h0000};
        regs[13] = ($signed(regs[12]) < $signed(regs[8])) ? 32'd1 : 32'd0;
        regs[14] = (regs[12] < regs[8]) ? 32'd1 : 32'd0;
        regs[15] = regs[9] << shiftA[4:0];
        regs[16] = $unsigned($signed(regs[12]) >>> shiftB[4:0]);
        regs[17] = regs[15] - regs[16];
        regs[18] = regs[13] + regs[14];
        expChain = (regs[17] ^ regs[11]) + regs[18];
        storedWord = regs[17];
        expStoreAddr = DataBase + 32'd8;
        // Link register holds the JAL address plus 4
        expFinal = 32'h11 + ResetVector + 32'd96;
        chainCheckPc = ResetVector + 32'd52;
        loadCheckPc = ResetVector + 32'd68;

        for (int i = 0; i < ProgLen; i++) begin
            if (i != 20 && i != 24 && i != 25) begin
                fetchAddr[numFetches] = ResetVector + 4 * i;
                numFetches++;
            end
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        while (active) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);

        fetchTotal: assert (fetchCount == numFetches)
            else reportProblem($sformatf("fetched %0d instructions instead of %0d",
                                         fetchCount, numFetches));
        writeTotal: assert (writeCount == 1)
            else reportProblem($sformatf("saw %0d bus writes instead of one", writeCount));
        $display("errors: %0d, fetches: %0d, bus writes: %0d", errorCount, fetchCount, writeCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // 200 cycles for each instruction of the program
    initial begin : watchdog
        repeat (16 + 200 * ProgLen) @(posedge clk);
        $display("watchdog expired, the core did not halt in time");
        $display("test failed");
        $finish;
    end

endmodule

/* tbMemory.sv */
// Avalon-MM slave memory for the core testbench, a program ROM at the reset vector and a data RAM
`include "mipsCpu_cfg.svh"

module tbMemory (
    input  logic clk,
    input  logic reset,
    input  logic [`MIPS_XLEN-1:0] address,
    input  logic [`MIPS_XLEN-1:0] writeData,
    input  logic read,
    input  logic write,
    output logic waitRequest,
    output logic [`MIPS_XLEN-1:0] readData
);

    localparam logic [31:0] Seed = 32'h8064d201;
    localparam logic [31:0] RomBase = `MIPS_RESET_VECTOR;

    // 256 program words, filled by the testbench before reset falls
    logic [31:0] rom [0:255];
    logic [31:0] ram [0:63];
    logic [63:0] written;
    logic [31:0] lcgState;
    logic [31:0] lcgNext;
    logic inRom;
    logic writeAccepted;

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Unwritten words read as a pattern of their full address
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    assign inRom = (address[31:10] == RomBase[31:10]);
    assign writeAccepted = write && !waitRequest && !inRom;
    assign lcgNext = nextRandom(lcgState);

    always_comb begin
        if (read !== 1'b1) begin
            readData = '0;
        end else if (inRom) begin
            readData = rom[address[9:2]];
        end else if (written[address[7:2]]) begin
            readData = ram[address[7:2]];
        end else begin
            readData = fillWord(address);
        end
    end

    initial begin
        lcgState = Seed;
        waitRequest = 1'b0;
    end

    // Stalls the master about one cycle in four
    always @(posedge clk) begin
        lcgState <= lcgNext;
        waitRequest <= (lcgNext[29:28] == 2'b00);
    end

    always @(posedge clk) begin
        if (reset) begin
            written <= '0;
        end else if (writeAccepted) begin
            ram[address[7:2]] <= writeData;
            written[address[7:2]] <= 1'b1;
        end
    end

endmodule

/* mipsCpuBus.sv */
// Top level of the multicycle MIPS core with an Avalon-MM master bus
`include "mipsCpu_cfg.svh"

module mipsCpuBus (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [`MIPS_XLEN-1:0] registerV0,
    output logic [`MIPS_XLEN-1:0] address,
    output logic [`MIPS_XLEN-1:0] writeData,
    output logic read,
    output logic write,
    input  logic waitRequest,
    output logic [3:0] byteEnable,
    input  logic [`MIPS_XLEN-1:0] readData
);

    mipsPkg::busReqT busReq;
    mipsPkg::aluOpE aluOp;
    logic reqValid;
    logic respValid;
    logic [`MIPS_XLEN-1:0] respData;
    logic [`MIPS_REG_ADDR_W-1:0] readAddrA;
    logic [`MIPS_REG_ADDR_W-1:0] readAddrB;
    logic [`MIPS_REG_ADDR_W-1:0] writeAddr;
    logic [`MIPS_XLEN-1:0] readDataA;
    logic [`MIPS_XLEN-1:0] readDataB;
    logic regWriteEn;
    logic [`MIPS_XLEN-1:0] regWriteData;
    logic [`MIPS_XLEN-1:0] aluA;
    logic [`MIPS_XLEN-1:0] aluB;
    logic [`MIPS_XLEN-1:0] aluResult;
    logic aluZero;

    cpuControl control (
        .clk(clk), .reset(reset),
        .busReq(busReq), .reqValid(reqValid),
        .respValid(respValid), .respData(respData),
        .readAddrA(readAddrA), .readAddrB(readAddrB), .writeAddr(writeAddr),
        .readDataA(readDataA), .readDataB(readDataB),
        .writeEn(regWriteEn), .writeData(regWriteData),
        .aluOp(aluOp), .aluA(aluA), .aluB(aluB),
        .aluResult(aluResult), .aluZero(aluZero),
        .active(active)
    );

    regFile registers (
        .clk(clk), .reset(reset), .writeEn(regWriteEn),
        .readAddrA(readAddrA), .readAddrB(readAddrB), .writeAddr(writeAddr),
        .writeData(regWriteData),
        .readDataA(readDataA), .readDataB(readDataB), .registerV0(registerV0)
    );

    alu arith (
        .aluOp(aluOp), .aluA(aluA), .aluB(aluB),
        .aluResult(aluResult), .aluZero(aluZero)
    );

    busPort master (
        .clk(clk), .reset(reset),
        .reqValid(reqValid), .busReq(busReq),
        .respValid(respValid), .respData(respData),
        .address(address), .writeData(writeData),
        .read(read), .write(write), .byteEnable(byteEnable),
        .waitRequest(waitRequest), .readData(readData)
    );

endmodule

/* busPort.sv */
// Avalon-MM master port that turns one registered core request into a bus transfer
`include "mipsCpu_cfg.svh"

module busPort (
    input  logic clk,
    input  logic reset,
    input  logic reqValid,
    input  mipsPkg::busReqT busReq,
    output logic respValid,
    output logic [`MIPS_XLEN-1:0] respData,
    output logic [`MIPS_XLEN-1:0] address,
    output logic [`MIPS_XLEN-1:0] writeData,
    output logic read,
    output logic write,
    output logic [3:0] byteEnable,
    input  logic waitRequest,
    input  logic [`MIPS_XLEN-1:0] readData
);

    logic busy;
    logic accepted;

    assign busy = read || write;
    assign accepted = busy && !waitRequest;

    // Word accesses only
    assign byteEnable = 4'b1111;

    always_ff @(posedge clk) begin
        if (reset) begin
            read <= 1'b0;
            write <= 1'b0;
            respValid <= 1'b0;
        end else begin
            respValid <= accepted;
            if (reqValid) begin
                read <= busReq.read;
                write <= busReq.write;
            end else if (accepted) begin
                read <= 1'b0;
                write <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reqValid) begin
            address <= busReq.address;
            writeData <= busReq.writeData;
        end
        if (accepted) begin
            respData <= readData;
        end
    end

    noReadAndWrite: assert property (@(posedge clk) disable iff (reset) !(read && write));

    holdDuringWait: assert property (@(posedge clk) disable iff (reset)
        (busy && waitRequest) |=> ($stable(address) && $stable(writeData)
                                   && $stable(read) && $stable(write)));

endmodule

/* alu.sv */
// Combinational ALU of the MIPS core with the equality flag used by BEQ and BNE
`include "mipsCpu_cfg.svh"

module alu (
    input  mipsPkg::aluOpE aluOp,
    input  logic [`MIPS_XLEN-1:0] aluA,
    input  logic [`MIPS_XLEN-1:0] aluB,
    output logic [`MIPS_XLEN-1:0] aluResult,
    output logic aluZero
);

    logic [`MIPS_XLEN-1:0] difference;
    logic [`MIPS_REG_ADDR_W-1:0] shiftAmount;
    logic signedLess;
    logic unsignedLess;

    assign difference = aluA - aluB;
    assign shiftAmount = aluB[`MIPS_REG_ADDR_W-1:0];
    assign signedLess = ($signed(aluA) < $signed(aluB));
    assign unsignedLess = (aluA < aluB);

    // Equal operands give a zero difference whatever aluOp selects
    assign aluZero = (difference == '0);

    always_comb begin
        case (aluOp)
            mipsPkg::aluAdd: begin
                aluResult = aluA + aluB;
            end
            mipsPkg::aluSub: begin
                aluResult = difference;
            end
            mipsPkg::aluAnd: begin
                aluResult = aluA & aluB;
            end
            mipsPkg::aluOr: begin
                aluResult = aluA | aluB;
            end
            mipsPkg::aluXor: begin
                aluResult = aluA ^ aluB;
            end
            mipsPkg::aluSlt: begin
                aluResult = {{(`MIPS_XLEN-1){1'b0}}, signedLess};
            end
            mipsPkg::aluSltu: begin
                aluResult = {{(`MIPS_XLEN-1){1'b0}}, unsignedLess};
            end
            mipsPkg::aluSll: begin
                aluResult = aluA << shiftAmount;
            end
            mipsPkg::aluSrl: begin
                aluResult = aluA >> shiftAmount;
            end
            mipsPkg::aluSra: begin
                aluResult = $unsigned($signed(aluA) >>> shiftAmount);
            end
            // Immediate into the upper half
            mipsPkg::aluLui: begin
                aluResult = {aluB[`MIPS_XLEN/2-1:0], {(`MIPS_XLEN/2){1'b0}}};
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

/* regFile.sv */
// Two-read one-write register file of the MIPS core, register 0 reads as zero
`include "mipsCpu_cfg.svh"

module regFile (
    input  logic clk,
    input  logic reset,
    input  logic writeEn,
    input  logic [`MIPS_REG_ADDR_W-1:0] readAddrA,
    input  logic [`MIPS_REG_ADDR_W-1:0] readAddrB,
    input  logic [`MIPS_REG_ADDR_W-1:0] writeAddr,
    input  logic [`MIPS_XLEN-1:0] writeData,
    output logic [`MIPS_XLEN-1:0] readDataA,
    output logic [`MIPS_XLEN-1:0] readDataB,
    output logic [`MIPS_XLEN-1:0] registerV0
);

    localparam int NumRegs = 2 ** `MIPS_REG_ADDR_W;

    // Register 0 is cleared by reset and never written
    logic [`MIPS_XLEN-1:0] regs [0:NumRegs-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // v0 is register 2
    assign registerV0 = regs[2];

    zeroReadsZero: assert property (@(posedge clk) disable iff (reset)
        (readAddrA != '0 || readDataA == '0) && (readAddrB != '0 || readDataB == '0));

endmodule

/* cpuControl.sv */
// Fetch/execute/memory sequencer of the MIPS core, holds PC and instruction and drives the datapath
`include "mipsCpu_cfg.svh"

module cpuControl (
    input  logic clk,
    input  logic reset,
    output mipsPkg::busReqT busReq,
    output logic reqValid,
    input  logic respValid,
    input  logic [`MIPS_XLEN-1:0] respData,
    output logic [`MIPS_REG_ADDR_W-1:0] readAddrA,
    output logic [`MIPS_REG_ADDR_W-1:0] readAddrB,
    output logic [`MIPS_REG_ADDR_W-1:0] writeAddr,
    input  logic [`MIPS_XLEN-1:0] readDataA,
    input  logic [`MIPS_XLEN-1:0] readDataB,
    output logic writeEn,
    output logic [`MIPS_XLEN-1:0] writeData,
    output mipsPkg::aluOpE aluOp,
    output logic [`MIPS_XLEN-1:0] aluA,
    output logic [`MIPS_XLEN-1:0] aluB,
    input  logic [`MIPS_XLEN-1:0] aluResult,
    input  logic aluZero,
    output logic active
);

    typedef enum logic [2:0] {
        stFetch, stFetchWait, stExecute, stMemWait, stHalt
    } stateE;

    stateE state;
    mipsPkg::instrT instr;
    logic [`MIPS_XLEN-1:0] pc;
    logic [`MIPS_XLEN-1:0] pcPlus4;
    logic [`MIPS_XLEN-1:0] nextPc;
    logic [`MIPS_XLEN-1:0] signImm;
    logic [`MIPS_XLEN-1:0] zeroImm;
    logic [`MIPS_XLEN-1:0] shiftAmount;
    logic [`MIPS_REG_ADDR_W-1:0] destReg;
    logic isLoad;
    logic isStore;
    logic aluWrite;
    logic linkWrite;
    logic outstanding;

    assign pcPlus4 = pc + `MIPS_XLEN'd4;
    assign signImm = {{(`MIPS_XLEN-16){instr.body.i.immediate[15]}}, instr.body.i.immediate};
    assign zeroImm = {{(`MIPS_XLEN-16){1'b0}}, instr.body.i.immediate};
    assign shiftAmount = {{(`MIPS_XLEN-`MIPS_REG_ADDR_W){1'b0}}, instr.body.r.shamt};
    assign readAddrA = instr.body.i.rs;
    assign readAddrB = instr.body.i.rt;
    assign isLoad = (instr.opcode == mipsPkg::opLw);
    assign isStore = (instr.opcode == mipsPkg::opSw);
    assign active = (state != stHalt);

    // Instruction decode
    always_comb begin
        aluOp = mipsPkg::aluAdd;
        aluA = readDataA;
        aluB = readDataB;
        aluWrite = 1'b0;
        linkWrite = 1'b0;
        destReg = instr.body.i.rt;
        nextPc = pcPlus4;
        case (instr.opcode)
            mipsPkg::opRtype: begin
                aluWrite = 1'b1;
                destReg = instr.body.r.rd;
                case (instr.body.r.funct)
                    mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluOp = mipsPkg::aluXor;
                    mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: aluOp = mipsPkg::aluSltu;
                    // Shifts move rt by the shamt field
                    mipsPkg::fnSll, mipsPkg::fnSrl, mipsPkg::fnSra: begin
                        aluA = readDataB;
                        aluB = shiftAmount;
                        if (instr.body.r.funct == mipsPkg::fnSll) begin
                            aluOp = mipsPkg::aluSll;
                        end else if (instr.body.r.funct == mipsPkg::fnSrl) begin
                            aluOp = mipsPkg::aluSrl;
                        end else begin
                            aluOp = mipsPkg::aluSra;
                        end
                    end
                    mipsPkg::fnJr: begin
                        aluWrite = 1'b0;
                        nextPc = readDataA;
                    end
                    default: aluWrite = 1'b0;
                endcase
            end
            mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu: begin
                aluB = signImm;
                aluWrite = 1'b1;
                if (instr.opcode == mipsPkg::opSlti) begin
                    aluOp = mipsPkg::aluSlt;
                end else if (instr.opcode == mipsPkg::opSltiu) begin
                    aluOp = mipsPkg::aluSltu;
                end
            end
            mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui: begin
                aluB = zeroImm;
                aluWrite = 1'b1;
                case (instr.opcode)
                    mipsPkg::opAndi: aluOp = mipsPkg::aluAnd;
                    mipsPkg::opOri:  aluOp = mipsPkg::aluOr;
                    mipsPkg::opXori: aluOp = mipsPkg::aluXor;
                    default:         aluOp = mipsPkg::aluLui;
                endcase
            end
            // Branches compare rs and rt through the subtractor
            mipsPkg::opBeq, mipsPkg::opBne: begin
                aluOp = mipsPkg::aluSub;
                if (aluZero == (instr.opcode == mipsPkg::opBeq)) begin
                    nextPc = pcPlus4 + {signImm[`MIPS_XLEN-3:0], 2'b00};
                end
            end
            mipsPkg::opJ, mipsPkg::opJal: begin
                nextPc = {pcPlus4[`MIPS_XLEN-1:`MIPS_XLEN-4], instr.body.target, 2'b00};
                linkWrite = (instr.opcode == mipsPkg::opJal);
                destReg = '1;
            end
            mipsPkg::opLw, mipsPkg::opSw: aluB = signImm;
            default: ;
        endcase
    end

    // Register write-back, ALU and link results in execute, load data on response
    always_comb begin
        writeEn = 1'b0;
        writeAddr = destReg;
        writeData = linkWrite ? pcPlus4 : aluResult;
        if (state == stExecute) begin
            writeEn = aluWrite || linkWrite;
        end else if (state == stMemWait && respValid && isLoad) begin
            writeEn = 1'b1;
            writeData = respData;
        end
    end

    // Execute issues either the data access or the next fetch
    always_comb begin
        reqValid = 1'b0;
        busReq.address = pc;
        busReq.writeData = readDataB;
        busReq.read = 1'b1;
        busReq.write = 1'b0;
        if (state == stFetch) begin
            reqValid = (pc != `MIPS_HALT_ADDR);
        end else if (state == stExecute) begin
            if (isLoad || isStore) begin
                reqValid = 1'b1;
                busReq.address = aluResult;
                busReq.read = isLoad;
                busReq.write = isStore;
            end else begin
                reqValid = (nextPc != `MIPS_HALT_ADDR);
                busReq.address = nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
            pc <= `MIPS_RESET_VECTOR;
        end else begin
            case (state)
                stFetch: state <= (pc == `MIPS_HALT_ADDR) ? stHalt : stFetchWait;
                stFetchWait: begin
                    if (respValid) begin
                        state <= stExecute;
                    end
                end
                stExecute: begin
                    pc <= nextPc;
                    if (isLoad || isStore) begin
                        state <= stMemWait;
                    end else if (nextPc == `MIPS_HALT_ADDR) begin
                        state <= stHalt;
                    end else begin
                        state <= stFetchWait;
                    end
                end
                stMemWait: begin
                    if (respValid) begin
                        state <= stFetch;
                    end
                end
                default: state <= stHalt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetchWait && respValid) begin
            instr <= respData;
        end
    end

    // One bus transaction in flight at most
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (reqValid) begin
            outstanding <= 1'b1;
        end else if (respValid) begin
            outstanding <= 1'b0;
        end
    end

    reqWhileBusy: assert property (@(posedge clk) disable iff (reset) reqValid |-> !outstanding);

endmodule

/* mipsPkg.sv */
// Shared opcode, ALU and bus types for the multicycle MIPS core, referenced by scoped name
`include "mipsCpu_cfg.svh"

package mipsPkg;

    // Primary opcodes handled by the core
    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddiu = 6'h09,
        opSlti  = 6'h0A,
        opSltiu = 6'h0B,
        opAndi  = 6'h0C,
        opOri   = 6'h0D,
        opXori  = 6'h0E,
        opLui   = 6'h0F,
        opLw    = 6'h23,
        opSw    = 6'h2B
    } opcodeE;

    // R-type function codes
    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnSrl  = 6'h02,
        fnSra  = 6'h03,
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2A,
        fnSltu = 6'h2B
    } functE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
        aluSll, aluSrl, aluSra, aluLui
    } aluOpE;

    typedef struct packed {
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [`MIPS_REG_ADDR_W-1:0] rd;
        logic [`MIPS_REG_ADDR_W-1:0] shamt;
        functE funct;
    } rFieldsT;

    typedef struct packed {
        logic [`MIPS_REG_ADDR_W-1:0] rs;
        logic [`MIPS_REG_ADDR_W-1:0] rt;
        logic [15:0] immediate;
    } iFieldsT;

    // Low 26 bits seen as R, I or J format
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
        logic [25:0] target;
    } instrBodyT;

    typedef struct packed {
        opcodeE opcode;
        instrBodyT body;
    } instrT;

    typedef struct packed {
        logic [`MIPS_XLEN-1:0] address;
        logic [`MIPS_XLEN-1:0] writeData;
        logic read;
        logic write;
    } busReqT;

endpackage

/* mipsCpu_cfg.svh */
// Core-wide width and address constants, included by every RTL file and the testbench
`ifndef MIPS_CPU_CFG_SVH
`define MIPS_CPU_CFG_SVH

// Data path and bus address width
`define MIPS_XLEN 32

// Register index width, 32 architectural registers
`define MIPS_REG_ADDR_W 5

// First instruction fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// A fetch from this address stops the core
// JR to register 0 is the usual way a program ends
`define MIPS_HALT_ADDR 32'h00000000

`endif
